//--- sim.f
verilog/ifu_pkg.sv
verilog/ifu_bpu.sv
verilog/ifu_pc_gen.sv
verilog/ifu_axi_master.sv
verilog/ifu_ifetch.sv
verilog/ifu.sv
testbench/ifu_assertions.sv
testbench/tb_ifu.sv

//--- Bender.yml
package:
  name: ifu

# rtl first, package before its users
sources:
  - verilog/ifu_pkg.sv
  - verilog/ifu_bpu.sv
  - verilog/ifu_pc_gen.sv
  - verilog/ifu_axi_master.sv
  - verilog/ifu_ifetch.sv
  - verilog/ifu.sv
  # simulation only
  - target: test
    files:
      - testbench/ifu_assertions.sv
      - testbench/tb_ifu.sv

//--- testbench/tb_ifu.sv
// ======================================================================
// testbench for the instruction fetch unit
// clock, reset, axi slave memory with random delays, control stimulus
// expected pc model and delivery checks
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_ifu import ifu_pkg::*; ();

    localparam int         CLK_HALF    = 4;  // 8 ns period
    localparam int         RST_CYCLES  = 8;
    localparam int         WAIT_LIMIT  = 500;
    localparam inst_addr_t ERR_ADDR    = 32'h0000_00A0;  // word 40
    localparam axi_resp_t  RESP_SLVERR = 2'b10;

    logic       clk;
    logic       arst_n_i;
    logic       jump_flag_i;
    inst_addr_t jump_addr_i;
    ctrl_bus_t  stall_flag_i;
    inst_data_t inst_o;
    inst_addr_t inst_addr_o;
    logic       inst_valid_o;
    logic       branch_taken_o;
    logic       read_resp_error_o;
    axi_ar_t    ar_o;
    logic       arvalid_o;
    logic       arready_i;
    axi_r_t     r_i;
    logic       rvalid_i;
    logic       rready_o;

    inst_data_t  mem [256];       // slave memory, word indexed
    logic        pred_taken [256];
    int          next_off [256];  // byte step to the next expected fetch
    logic [15:0] lfsr_q;
    inst_addr_t  exp_pc;          // model of the fetch pc
    int          n_delivered;
    int          n_errors;
    logic        err_prev;

    ifu uut (.*);

    bind ifu ifu_assertions u_ifu_assertions (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("mismatch at %0t: %s", $time, what));
    endtask

    task automatic count_wait(inout int cnt, input string what);
        cnt++;
        if (cnt > WAIT_LIMIT) begin
            stop_with_failure($sformatf("timeout while waiting for %s", what));
        end
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #1;  // inputs move just after the edge
    endtask

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        repeat (n) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic inst_data_t enc_branch(input int off);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_data_t enc_jal(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    // jal always taken, branches only when pointing backwards
    task automatic plant(input int idx, input logic is_jal, input int off);
        mem[idx] = is_jal ? enc_jal(off) : enc_branch(off);
        pred_taken[idx] = is_jal || (off < 0);
        next_off[idx] = pred_taken[idx] ? off : 4;
    endtask

    task automatic fill_memory();
        logic [31:0] w;
        for (int i = 0; i < 256; i++) begin
            draw_bits(25, w);
            mem[i] = {w[24:0], 7'b0010011};  // op-imm filler
            pred_taken[i] = 1'b0;
            next_off[i] = 4;
        end
        plant(3, 1'b0, 12);     // forward branch, falls through
        plant(6, 1'b1, 24);     // jal to word 12
        plant(14, 1'b0, -20);   // loop back to word 9
        plant(46, 1'b1, -8);    // jal back to word 44
        plant(110, 1'b1, -40);  // jal back to word 100
    endtask

    task automatic check_delivery();
        int idx;
        idx = int'(inst_addr_o[9:2]);
        assert (inst_addr_o == exp_pc)
            else report_mismatch($sformatf("inst_addr_o %h, expected %h", inst_addr_o, exp_pc));
        assert (inst_o == mem[idx])
            else report_mismatch($sformatf("inst_o %h at %h, memory holds %h",
                                           inst_o, inst_addr_o, mem[idx]));
        assert (branch_taken_o == pred_taken[idx])
            else report_mismatch($sformatf("branch_taken_o %b at %h", branch_taken_o,
                                           inst_addr_o));
        assert (!read_resp_error_o)
            else report_mismatch("read_resp_error_o together with inst_valid_o");
        exp_pc = inst_addr_o + inst_addr_t'(next_off[idx]);
        n_delivered++;
    endtask

    task automatic check_error();
        assert (exp_pc == ERR_ADDR)
            else report_mismatch($sformatf("read error while expecting %h", exp_pc));
        assert (!err_prev)
            else report_mismatch("read_resp_error_o high for more than one cycle");
        exp_pc = exp_pc + 32'd4;  // fetch goes on past the bad word
        err_prev = 1'b1;
        n_errors++;
    endtask

    // outputs sampled mid-cycle, a held output counts once stall drops
    always @(negedge clk) begin : delivery_check
        if (arst_n_i && !stall_flag_i[CU_STALL]) begin
            if (inst_valid_o) begin
                check_delivery();
            end
            if (read_resp_error_o) begin
                check_error();
            end else begin
                err_prev = 1'b0;
            end
        end
        if (jump_flag_i) begin
            exp_pc = jump_addr_i;  // taken on the coming edge
        end
        if (uut.u_ifu_assertions.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion fired");
        end
    end

    initial begin : slave_model
        logic [31:0] dly;
        inst_addr_t  raddr;
        logic        hs;
        int          cnt;
        cnt = 0;
        drive_edge();
        while (!arst_n_i) begin
            drive_edge();
            count_wait(cnt, "reset release");
        end
        forever begin
            cnt = 0;
            do begin
                @(negedge clk);
                count_wait(cnt, "a read request from the DUT");
            end while (!arvalid_o);
            draw_bits(2, dly);
            repeat (dly + 1) drive_edge();
            arready_i = 1'b1;
            raddr = ar_o.araddr;
            drive_edge();  // ar handshake
            arready_i = 1'b0;
            draw_bits(2, dly);
            repeat (dly) drive_edge();
            rvalid_i = 1'b1;
            r_i.rdata = mem[raddr[9:2]];
            r_i.rresp = (raddr == ERR_ADDR) ? RESP_SLVERR : AXI_RESP_OKAY;
            cnt = 0;
            do begin
                @(negedge clk);
                hs = rready_o;
                drive_edge();
                count_wait(cnt, "rready from the DUT");
            end while (!hs);
            rvalid_i = 1'b0;
        end
    end

    task automatic wait_for_progress(input int deliveries, input int errors);
        int cnt;
        int want_d;
        int want_e;
        cnt = 0;
        want_d = n_delivered + deliveries;
        want_e = n_errors + errors;
        while (n_delivered < want_d || n_errors < want_e) begin
            drive_edge();
            count_wait(cnt, "instructions from the fetch unit");
        end
    endtask

    // either an ar still pending, or the data phase before rvalid
    task automatic wait_for_bus(input logic data_phase);
        int    cnt;
        logic  hit;
        string what;
        cnt = 0;
        what = data_phase ? "a read in its data phase" : "a pending read address";
        do begin
            @(negedge clk);
            count_wait(cnt, what);
            hit = data_phase ? (rready_o && !rvalid_i) : arvalid_o;
        end while (!hit);
        drive_edge();
    endtask

    task automatic redirect(input inst_addr_t target, input logic with_flush);
        jump_flag_i = 1'b1;
        jump_addr_i = target;
        stall_flag_i[CU_FLUSH] = with_flush;
        drive_edge();
        jump_flag_i = 1'b0;
        stall_flag_i[CU_FLUSH] = 1'b0;
    endtask

    task automatic hold_stall(input int cycles);
        stall_flag_i[CU_STALL] = 1'b1;
        repeat (cycles) drive_edge();
        stall_flag_i[CU_STALL] = 1'b0;
    endtask

    // stall with an instruction in if/id, then jump and flush under the stall
    task automatic flush_held_inst(input int cycles, input inst_addr_t target);
        int cnt;
        cnt = 0;
        do begin
            drive_edge();
            count_wait(cnt, "an instruction to hold in the if/id register");
        end while (!inst_valid_o);
        stall_flag_i[CU_STALL] = 1'b1;  // held inst is never counted
        repeat (cycles) drive_edge();
        redirect(target, 1'b1);
        stall_flag_i[CU_STALL] = 1'b0;
    endtask

    initial begin : stimulus
        arst_n_i = 1'b1;
        jump_flag_i = 1'b0;
        jump_addr_i = '0;
        stall_flag_i = '0;
        arready_i = 1'b0;
        rvalid_i = 1'b0;
        r_i = '0;
        lfsr_q = 16'd46771;
        exp_pc = RESET_PC;
        n_delivered = 0;
        n_errors = 0;
        err_prev = 1'b0;
        fill_memory();
        #1 arst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n_i = 1'b1;
        wait_for_progress(14, 0);  // sequential, fwd branch, jal, backward loop
        wait_for_bus(1'b1);
        hold_stall(5);  // response waits at the slave
        wait_for_progress(3, 0);
        flush_held_inst(3, ERR_ADDR - 32'd12);  // flush wins over the stall
        wait_for_progress(6, 1);
        wait_for_bus(1'b0);
        redirect(32'h0000_0190, 1'b0);  // word 100, ar still pending
        wait_for_progress(14, 0);
        wait_for_bus(1'b1);
        redirect(32'h0000_0320, 1'b0);  // word 200, read outstanding
        wait_for_progress(5, 0);
        repeat (4) drive_edge();
        assert (n_errors == 1)
            else report_mismatch($sformatf("%0d read errors, expected one", n_errors));
        if (uut.u_ifu_assertions.fail_count != 0) begin
            stop_with_failure("a bound protocol assertion fired");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/ifu_assertions.sv
// ======================================================================
// concurrent checks bound into the fetch unit top level
// axi read rules, reset values, stall hold and flush
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu_assertions import ifu_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input ctrl_bus_t  stall_flag_i,
    input axi_ar_t    ar_o,
    input logic       arvalid_o,
    input logic       arready_i,
    input logic       rvalid_i,
    input logic       rready_o,
    input inst_data_t inst_o,
    input inst_addr_t inst_addr_o,
    input logic       inst_valid_o,
    input logic       branch_taken_o,
    input logic       read_resp_error_o
);

    int   fail_count = 0;  // failed properties so far
    logic busy_q;          // ar accepted, r still owed
    logic stall;
    logic flush;

    assign stall = stall_flag_i[CU_STALL];
    assign flush = stall_flag_i[CU_FLUSH];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (arvalid_o && arready_i) begin
            busy_q <= 1'b1;
        end else if (rvalid_i && rready_o) begin
            busy_q <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else begin
        $error("read address dropped or changed before arready");
        fail_count++;
    end

    one_outstanding: assert property (@(posedge clk) disable iff (!arst_n_i)
        busy_q |-> !arvalid_o)
    else begin
        $error("second read address issued before the read data");
        fail_count++;
    end

    no_rready_in_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall |-> !rready_o)
    else begin
        $error("rready raised while the stage is stalled");
        fail_count++;
    end

    // not disabled, this one looks at reset itself
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !arvalid_o && !rready_o && !inst_valid_o
                      && !branch_taken_o && !read_resp_error_o)
    else begin
        $error("control output high during reset");
        fail_count++;
    end

    stall_holds: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall && !flush |=> $stable(inst_o) && $stable(inst_addr_o)
                            && $stable(inst_valid_o) && $stable(branch_taken_o)
                            && $stable(read_resp_error_o))
    else begin
        $error("if/id outputs moved during stall");
        fail_count++;
    end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush |=> !inst_valid_o)
    else begin
        $error("inst_valid_o still high after flush");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verilog/ifu.sv
// ======================================================================
// instruction fetch unit top level
// pc generator, axi read master and if/id stage
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu import ifu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,

    // control unit
    input  logic       jump_flag_i,        // redirect
    input  inst_addr_t jump_addr_i,
    input  ctrl_bus_t  stall_flag_i,       // stall / flush bits

    // to decode
    output inst_data_t inst_o,
    output inst_addr_t inst_addr_o,
    output logic       inst_valid_o,
    output logic       branch_taken_o,
    output logic       read_resp_error_o,

    // axi read channels
    output axi_ar_t    ar_o,
    output logic       arvalid_o,
    input  logic       arready_i,
    input  axi_r_t     r_i,
    input  logic       rvalid_i,
    output logic       rready_o
);

    logic       stall;
    logic       flush;
    inst_addr_t pc;           // next fetch address
    inst_data_t resp_data;
    inst_addr_t resp_addr;
    logic       resp_valid;
    logic       resp_error;
    logic       fetch_done;
    logic       pred_taken;
    inst_addr_t pred_target;

    assign stall = stall_flag_i[CU_STALL];
    assign flush = stall_flag_i[CU_FLUSH];

    ifu_pc_gen u_pc_gen (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .jump_flag_i  (jump_flag_i),
        .jump_addr_i  (jump_addr_i),
        .pred_taken_i (pred_taken),
        .pred_target_i(pred_target),
        .fetch_done_i (fetch_done),
        .pc_o         (pc)
    );

    ifu_axi_master u_axi_master (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall),
        .jump_flag_i (jump_flag_i),
        .pc_i        (pc),
        .ar_o        (ar_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .r_i         (r_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .resp_data_o (resp_data),
        .resp_addr_o (resp_addr),
        .resp_valid_o(resp_valid),
        .resp_error_o(resp_error),
        .fetch_done_o(fetch_done)
    );

    ifu_ifetch u_ifetch (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .stall_i          (stall),
        .flush_i          (flush),
        .resp_data_i      (resp_data),
        .resp_addr_i      (resp_addr),
        .resp_valid_i     (resp_valid),
        .resp_error_i     (resp_error),
        .pred_taken_o     (pred_taken),
        .pred_target_o    (pred_target),
        .inst_o           (inst_o),
        .inst_addr_o      (inst_addr_o),
        .inst_valid_o     (inst_valid_o),
        .branch_taken_o   (branch_taken_o),
        .read_resp_error_o(read_resp_error_o)
    );

endmodule

`default_nettype wire

//--- verilog/ifu_ifetch.sv
// ======================================================================
// if/id pipeline register with stall and flush
// holds the static predictor on the response path
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu_ifetch import ifu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,

    input  logic       stall_i,            // hold everything
    input  logic       flush_i,            // drop valid flags, wins over stall

    // response from the axi master
    input  inst_data_t resp_data_i,
    input  inst_addr_t resp_addr_i,
    input  logic       resp_valid_i,
    input  logic       resp_error_i,

    // prediction, same cycle as the response
    output logic       pred_taken_o,
    output inst_addr_t pred_target_o,

    // to decode
    output inst_data_t inst_o,
    output inst_addr_t inst_addr_o,
    output logic       inst_valid_o,
    output logic       branch_taken_o,
    output logic       read_resp_error_o
);

    inst_data_t inst_q;
    inst_addr_t inst_addr_q;
    logic       valid_q;
    logic       taken_q;
    logic       error_q;
    logic       load;

    ifu_bpu u_bpu (
        .inst_i     (resp_data_i),
        .inst_addr_i(resp_addr_i),
        .valid_i    (resp_valid_i),   // no prediction on errors
        .taken_o    (pred_taken_o),
        .target_o   (pred_target_o)
    );

    assign load = resp_valid_i && !stall_i && !flush_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            taken_q <= 1'b0;
            error_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            taken_q <= 1'b0;
            error_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= resp_valid_i;                  // one cycle per inst
            taken_q <= resp_valid_i && pred_taken_o;
            error_q <= resp_error_i;                  // single cycle flag
        end
    end

    // payload only moves with a new instruction
    always_ff @(posedge clk) begin
        if (load) begin
            inst_q      <= resp_data_i;
            inst_addr_q <= resp_addr_i;
        end
    end

    assign inst_o            = inst_q;
    assign inst_addr_o       = inst_addr_q;
    assign inst_valid_o      = valid_q;
    assign branch_taken_o    = taken_q;
    assign read_resp_error_o = error_q;

endmodule

`default_nettype wire

//--- verilog/ifu_axi_master.sv
// ======================================================================
// single outstanding axi4 read master for instruction fetch
// discards responses overtaken by a redirect, flags slave errors
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu_axi_master import ifu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,

    input  logic       stall_i,       // if stage held
    input  logic       jump_flag_i,   // redirect, old path is dead
    input  inst_addr_t pc_i,          // address to fetch next

    // axi read address channel
    output axi_ar_t    ar_o,
    output logic       arvalid_o,
    input  logic       arready_i,

    // axi read data channel
    input  axi_r_t     r_i,
    input  logic       rvalid_i,
    output logic       rready_o,

    // towards the fetch stage
    output inst_data_t resp_data_o,
    output inst_addr_t resp_addr_o,
    output logic       resp_valid_o,  // good, live instruction
    output logic       resp_error_o,  // slave answered with an error
    output logic       fetch_done_o   // pc may advance
);

    typedef enum logic [1:0] {
        ST_IDLE,  // nothing in flight
        ST_ADDR,  // ar presented, waiting for arready
        ST_DATA   // ar accepted, waiting for r
    } state_e;

    state_e     state_q;
    state_e     state_d;
    inst_addr_t addr_q;       // address of the read in flight
    logic       discard_q;    // redirect seen while busy
    logic       discard;
    logic       start;
    logic       r_hs;
    logic       resp_ok;

    assign start   = (state_q == ST_IDLE) && !stall_i && !jump_flag_i;
    assign r_hs    = rvalid_i && rready_o;
    assign discard = discard_q || jump_flag_i;  // redirect on the r edge too
    assign resp_ok = (r_i.rresp == AXI_RESP_OKAY);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (arready_i) begin
                    state_d = ST_DATA;  // ar handshake
                end
            end
            ST_DATA: begin
                if (r_hs) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == ST_DATA) && r_hs) begin
                discard_q <= 1'b0;  // stale response drained
            end else if (jump_flag_i && (state_q != ST_IDLE)) begin
                discard_q <= 1'b1;  // ar cannot be withdrawn
            end
        end
    end

    // address held stable for the whole request
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= pc_i;
        end
    end

    assign ar_o.araddr = addr_q;
    assign arvalid_o   = (state_q == ST_ADDR);
    assign rready_o    = (state_q == ST_DATA) && !stall_i;  // response waits at slave

    assign resp_data_o  = r_i.rdata;
    assign resp_addr_o  = addr_q;
    assign resp_valid_o = r_hs && !discard && resp_ok;
    assign resp_error_o = r_hs && !discard && !resp_ok;
    assign fetch_done_o = r_hs && !discard;  // error still advances pc

endmodule

`default_nettype wire

//--- verilog/ifu_pc_gen.sv
// ======================================================================
// fetch pc register
// redirect, predicted target or sequential step per fetch
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_gen import ifu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,

    input  logic       jump_flag_i,    // redirect from control unit
    input  inst_addr_t jump_addr_i,    // redirect target

    input  logic       pred_taken_i,   // bpu says taken
    input  inst_addr_t pred_target_i,  // bpu target
    input  logic       fetch_done_i,   // response consumed, not discarded

    output inst_addr_t pc_o            // next address to request
);

    inst_addr_t pc_q;
    inst_addr_t pc_d;
    inst_addr_t pc_seq;

    assign pc_seq = pc_q + INST_STEP;  // plain sequential fetch

    // redirect beats prediction, prediction beats +4
    always_comb begin
        pc_d = pc_q;  // hold by default
        if (jump_flag_i) begin
            pc_d = jump_addr_i;
        end else if (fetch_done_i) begin
            if (pred_taken_i) begin
                pc_d = pred_target_i;  // backward branch or jal
            end else begin
                pc_d = pc_seq;  // also taken on a read error
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- verilog/ifu_bpu.sv
// ======================================================================
// static branch predictor
// backward conditional branches and jal predicted taken
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ifu_bpu import ifu_pkg::*; (
    input  inst_data_t inst_i,       // fetched word
    input  inst_addr_t inst_addr_i,  // its address
    input  logic       valid_i,      // word is a real instruction
    output logic       taken_o,
    output inst_addr_t target_o
);

    opcode_t    opcode;
    logic       is_branch;
    logic       is_jal;
    inst_addr_t b_imm;
    inst_addr_t j_imm;

    assign opcode    = inst_i[6:0];
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);

    // b-type imm[12|10:5|4:1|11], bit 0 implied zero
    assign b_imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};

    // j-type imm[20|10:1|11|19:12]
    assign j_imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};

    // sign bit set means backward, loop-closing branch
    assign taken_o = valid_i && (is_jal || (is_branch && inst_i[31]));

    assign target_o = inst_addr_i + (is_jal ? j_imm : b_imm);  // pc relative

endmodule

`default_nettype wire

//--- verilog/ifu_pkg.sv
// ======================================================================
// instruction fetch unit package
// widths, reset pc, opcodes, control bus bits and axi read structs
// ======================================================================
`default_nettype none

package ifu_pkg;

    localparam int INST_ADDR_WIDTH = 32;  // fetch address width
    localparam int INST_DATA_WIDTH = 32;  // instruction word width
    localparam int CU_BUS_WIDTH    = 2;   // stall / flush bus
    localparam int OPC_WIDTH       = 7;   // rv32 major opcode
    localparam int AXI_RESP_WIDTH  = 2;

    typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;
    typedef logic [INST_DATA_WIDTH-1:0] inst_data_t;
    typedef logic [CU_BUS_WIDTH-1:0]    ctrl_bus_t;
    typedef logic [OPC_WIDTH-1:0]       opcode_t;
    typedef logic [AXI_RESP_WIDTH-1:0]  axi_resp_t;

    localparam int CU_STALL = 0;  // hold the if stage
    localparam int CU_FLUSH = 1;  // clear the if/id register

    localparam inst_addr_t RESET_PC  = 32'h0000_0000;
    localparam inst_addr_t INST_STEP = 32'd4;  // no compressed insts

    localparam opcode_t OPC_BRANCH = 7'b1100011;  // b-type
    localparam opcode_t OPC_JAL    = 7'b1101111;  // j-type

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // read address channel, constant fields left to the slave
    typedef struct packed {
        inst_addr_t araddr;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        inst_data_t rdata;
        axi_resp_t  rresp;
    } axi_r_t;

endpackage

`default_nettype wire
